//--- src/xv_pkg.sv
// shared widths, types, register numbers and interrupt bits for the video controller
`default_nettype none

package xv_pkg;

    // VRAM geometry
    localparam int VRAM_ADDR_W  = 10;               // 1024 words
    localparam int WORD_W       = 16;               // bus register and VRAM word width
    localparam int INTR_W       = 4;                // one bit per interrupt source

    typedef logic [WORD_W-1:0]      word_t;         // 16-bit data word
    typedef logic [VRAM_ADDR_W-1:0] addr_t;         // VRAM word address
    typedef logic [INTR_W-1:0]      intr_t;         // interrupt vector

    // interrupt bit assignment
    localparam int    INTR_BLIT_BIT = 1;            // blit fill done
    // bits only software can raise, everything except blit done
    localparam intr_t INTR_SW_BITS  = ~(intr_t'(1) << INTR_BLIT_BIT);

    // main register numbers (4-bit bus field)
    localparam logic [3:0] REG_INT_CTRL     = 4'h0; // mask (byte 0), status/clear (byte 1)
    localparam logic [3:0] REG_WR_ADDR      = 4'h1; // VRAM write pointer
    localparam logic [3:0] REG_DATA         = 4'h2; // VRAM data port
    localparam logic [3:0] REG_RD_ADDR      = 4'h3; // VRAM read pointer
    localparam logic [3:0] REG_BLIT_ADDR    = 4'h4; // fill start address
    localparam logic [3:0] REG_BLIT_COUNT   = 4'h5; // fill length minus one, commit starts
    localparam logic [3:0] REG_BLIT_VALUE   = 4'h6; // fill word
    localparam logic [3:0] REG_SYS_CTRL     = 4'h7; // blit busy, software interrupt

    // one VRAM request, same layout for every requester
    typedef struct packed {
        logic           sel;        // request active
        logic           wr;         // 1 = write, 0 = read
        logic [3:0]     wr_mask;    // nibble enables, bit 3 = high nibble
        addr_t          addr;       // word address
        word_t          data;       // write data
    } vram_req_t;

endpackage

`default_nettype wire

//--- src/bus_regs.sv
// byte-lane CPU register file with VRAM pointers, read buffer and control strobes
`default_nettype none

module bus_regs (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               bus_cs_n_i,     // access strobe, active low
    input  wire logic               bus_rd_nwr_i,   // 1 = read
    input  wire logic [3:0]         bus_reg_num_i,
    input  wire logic               bus_bytesel_i,  // 0 = high byte, 1 = low byte
    input  wire logic [7:0]         bus_data_i,
    output logic      [7:0]         bus_data_o,
    input  wire xv_pkg::word_t      vram_data_i,    // registered VRAM read word
    input  wire logic               blit_busy_i,
    input  wire xv_pkg::intr_t      intr_status_i,
    output xv_pkg::vram_req_t       regs_req_o,
    output logic                    blit_start_o,
    output xv_pkg::addr_t           blit_addr_o,
    output xv_pkg::word_t           blit_count_o,
    output xv_pkg::word_t           blit_value_o,
    output xv_pkg::intr_t           intr_mask_o,
    output xv_pkg::intr_t           intr_clear_o,
    output xv_pkg::intr_t           sw_intr_o
);
    import xv_pkg::*;

    logic           wr_hi;          // byte 0 write, latch only
    logic           commit;         // byte 1 write, whole word
    logic           rd_acc;         // any read
    logic           blit_go;        // accepted fill start
    logic [7:0]     hi_byte;
    logic [1:0]     rd_pend;        // read request age, buffer loads from bit 1
    word_t          wr_word;
    word_t          wr_addr;
    word_t          rd_addr;
    word_t          rd_next;
    word_t          rd_buf;
    word_t          blit_addr;
    word_t          rd_word;

    assign wr_hi    = ~bus_cs_n_i & ~bus_rd_nwr_i & ~bus_bytesel_i;
    assign commit   = ~bus_cs_n_i & ~bus_rd_nwr_i & bus_bytesel_i;
    assign rd_acc   = ~bus_cs_n_i & bus_rd_nwr_i;
    assign wr_word  = {hi_byte, bus_data_i};
    assign rd_next  = rd_addr + 16'd1;
    // start ignored while busy or while a start is still in flight
    assign blit_go  = commit && (bus_reg_num_i == REG_BLIT_COUNT) && !blit_busy_i && !blit_start_o;
    assign blit_addr_o = blit_addr[VRAM_ADDR_W-1:0];    // upper bits unused

    // read word mux, byte picked at the strobe
    always_comb begin
        case (bus_reg_num_i)
            REG_INT_CTRL:   rd_word = {4'h0, intr_mask_o, 4'h0, intr_status_i};
            REG_WR_ADDR:    rd_word = wr_addr;
            REG_DATA:       rd_word = rd_buf;
            REG_RD_ADDR:    rd_word = rd_addr;
            REG_BLIT_ADDR:  rd_word = blit_addr;
            REG_BLIT_COUNT: rd_word = blit_count_o;
            REG_BLIT_VALUE: rd_word = blit_value_o;
            REG_SYS_CTRL:   rd_word = {15'h0, blit_busy_i};   // busy in bit 0
            default:        rd_word = '0;
        endcase
    end

    // data-path registers
    always_ff @(posedge clk) begin
        if (wr_hi) begin
            hi_byte <= bus_data_i;                  // held until the byte 1 commit
        end
        if (rd_pend[1]) begin
            rd_buf <= vram_data_i;                  // two cycles after the read request
        end
        if (commit && bus_reg_num_i == REG_BLIT_ADDR) begin
            blit_addr <= wr_word;
        end
        if (commit && bus_reg_num_i == REG_BLIT_VALUE) begin
            blit_value_o <= wr_word;
        end
        if (blit_go) begin
            blit_count_o <= wr_word;                // valid together with the start strobe
        end
    end

    // control state, pointers and strobes
    always_ff @(posedge clk) begin
        if (reset_i) begin
            bus_data_o      <= 8'h00;
            regs_req_o      <= '0;
            blit_start_o    <= 1'b0;
            intr_mask_o     <= '0;
            intr_clear_o    <= '0;
            sw_intr_o       <= '0;
            wr_addr         <= '0;
            rd_addr         <= '0;
            rd_pend         <= '0;
        end else begin
            regs_req_o.sel  <= 1'b0;                // request lasts one cycle
            blit_start_o    <= blit_go;
            intr_clear_o    <= '0;
            sw_intr_o       <= '0;
            rd_pend         <= {rd_pend[0], 1'b0};

            if (wr_hi && bus_reg_num_i == REG_INT_CTRL) begin
                intr_mask_o <= bus_data_i[3:0];     // mask takes effect on byte 0
            end

            if (commit) begin
                case (bus_reg_num_i)
                    REG_INT_CTRL: intr_clear_o <= bus_data_i[3:0];
                    REG_WR_ADDR:  wr_addr <= wr_word;
                    REG_DATA: begin
                        regs_req_o <= '{sel: 1'b1, wr: 1'b1, wr_mask: 4'hF,
                                        addr: wr_addr[VRAM_ADDR_W-1:0], data: wr_word};
                        wr_addr <= wr_addr + 16'd1; // auto increment
                    end
                    REG_RD_ADDR: begin
                        rd_addr     <= wr_word;
                        regs_req_o  <= '{sel: 1'b1, wr: 1'b0, wr_mask: 4'h0,
                                         addr: wr_word[VRAM_ADDR_W-1:0], data: '0};
                        rd_pend[0]  <= 1'b1;        // prefetch from the new pointer
                    end
                    REG_SYS_CTRL: sw_intr_o <= bus_data_i[3:0];
                    default: ;
                endcase
            end

            if (rd_acc) begin
                bus_data_o <= bus_bytesel_i ? rd_word[7:0] : rd_word[15:8];
                if (bus_bytesel_i && bus_reg_num_i == REG_DATA) begin
                    rd_addr     <= rd_next;         // low byte read advances
                    regs_req_o  <= '{sel: 1'b1, wr: 1'b0, wr_mask: 4'h0,
                                     addr: rd_next[VRAM_ADDR_W-1:0], data: '0};
                    rd_pend[0]  <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/blit_fill.sv
// fill engine writing one value to a counted run of VRAM words
`default_nettype none

module blit_fill (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               start_i,        // one-cycle start strobe
    input  wire xv_pkg::addr_t      addr_i,         // first word
    input  wire xv_pkg::word_t      count_i,        // words minus one
    input  wire xv_pkg::word_t      value_i,        // fill word
    input  wire logic               ack_i,          // write accepted this cycle
    output xv_pkg::vram_req_t       blit_req_o,
    output logic                    busy_o,
    output logic                    done_o          // one-cycle completion pulse
);
    import xv_pkg::*;

    addr_t      ptr;            // next word to write
    word_t      remain;         // words left after the current one
    word_t      value;
    logic       last_ack;

    assign last_ack = busy_o && ack_i && (remain == '0);

    // request held until acked, full nibble mask
    always_comb begin
        blit_req_o          = '0;
        blit_req_o.sel      = busy_o;
        blit_req_o.wr       = 1'b1;
        blit_req_o.wr_mask  = 4'hF;
        blit_req_o.addr     = ptr;
        blit_req_o.data     = value;
    end

    // parameters and walking pointer
    always_ff @(posedge clk) begin
        if (start_i && !busy_o) begin
            ptr     <= addr_i;
            remain  <= count_i;
            value   <= value_i;
        end else if (busy_o && ack_i) begin
            ptr     <= ptr + 1'b1;          // wraps at end of VRAM
            remain  <= remain - 16'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_o  <= 1'b0;
            done_o  <= 1'b0;
        end else begin
            done_o  <= last_ack;            // falls with busy
            if (start_i && !busy_o) begin
                busy_o <= 1'b1;
            end else if (last_ack) begin
                busy_o <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/vram_arb.sv
// VRAM storage with fixed-priority register/blit selection and registered read word
`default_nettype none

module vram_arb (
    input  wire logic               clk,
    input  wire xv_pkg::vram_req_t  regs_req_i,     // CPU register side, always wins
    input  wire xv_pkg::vram_req_t  blit_req_i,     // fill unit, waits for ack
    output logic                    blit_ack_o,
    output xv_pkg::word_t           vram_data_o     // valid one cycle after a read
);
    import xv_pkg::*;

    localparam int VRAM_WORDS = 1 << VRAM_ADDR_W;

    word_t      mem [VRAM_WORDS];
    vram_req_t  req;                // winning request this cycle

    // blit only goes through on a cycle with no register request
    assign blit_ack_o = blit_req_i.sel & ~regs_req_i.sel;

    always_comb begin
        if (regs_req_i.sel) begin
            req = regs_req_i;
        end else begin
            req = blit_req_i;
        end
    end

    // nibble-masked write
    always_ff @(posedge clk) begin
        if (req.sel && req.wr) begin
            for (int n = 0; n < 4; n++) begin
                if (req.wr_mask[n]) begin
                    mem[req.addr][n*4 +: 4] <= req.data[n*4 +: 4];
                end
            end
        end
    end

    // read word only moves on a read, so it holds across blit writes
    always_ff @(posedge clk) begin
        if (req.sel && !req.wr) begin
            vram_data_o <= mem[req.addr];
        end
    end

endmodule

`default_nettype wire

//--- src/intr_ctrl.sv
// interrupt pending status and CPU interrupt strobe
`default_nettype none

module intr_ctrl (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire xv_pkg::intr_t      sw_intr_i,      // software signal from SYS_CTRL
    input  wire logic               blit_done_i,
    input  wire xv_pkg::intr_t      mask_i,
    input  wire xv_pkg::intr_t      clear_i,        // one-cycle clear strobe
    output xv_pkg::intr_t           status_o,       // pending, masked or not
    output logic                    bus_intr_o
);
    import xv_pkg::*;

    intr_t  intr_src;               // bits signalled this cycle

    always_comb begin
        intr_src = sw_intr_i & INTR_SW_BITS;
        intr_src[INTR_BLIT_BIT] = sw_intr_i[INTR_BLIT_BIT] | blit_done_i;  // shared bit
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            status_o    <= '0;
            bus_intr_o  <= 1'b0;
        end else begin
            // pulse only for enabled bits that are newly pending
            bus_intr_o  <= |(intr_src & mask_i & ~status_o);
            status_o    <= (status_o | intr_src) & ~clear_i;
        end
    end

endmodule

`default_nettype wire

//--- src/xosera_core.sv
// top level connecting register file, fill unit, VRAM arbiter and interrupt logic
`default_nettype none

module xosera_core (
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           bus_cs_n_i,
    input  wire logic           bus_rd_nwr_i,
    input  wire logic [3:0]     bus_reg_num_i,
    input  wire logic           bus_bytesel_i,
    input  wire logic [7:0]     bus_data_i,
    output logic      [7:0]     bus_data_o,
    output logic                bus_intr_o
);
    import xv_pkg::*;

    vram_req_t  regs_req;
    vram_req_t  blit_req;
    logic       blit_ack;
    word_t      vram_data;          // shared read word
    logic       blit_start;
    addr_t      blit_addr;
    word_t      blit_count;
    word_t      blit_value;
    logic       blit_busy;
    logic       blit_done;          // feeds INTR_BLIT_BIT
    intr_t      intr_mask;
    intr_t      intr_clear;
    intr_t      intr_status;
    intr_t      sw_intr;

    bus_regs u_bus_regs (
        .clk            (clk),
        .reset_i        (reset_i),
        .bus_cs_n_i     (bus_cs_n_i),
        .bus_rd_nwr_i   (bus_rd_nwr_i),
        .bus_reg_num_i  (bus_reg_num_i),
        .bus_bytesel_i  (bus_bytesel_i),
        .bus_data_i     (bus_data_i),
        .bus_data_o     (bus_data_o),
        .vram_data_i    (vram_data),
        .blit_busy_i    (blit_busy),
        .intr_status_i  (intr_status),
        .regs_req_o     (regs_req),
        .blit_start_o   (blit_start),
        .blit_addr_o    (blit_addr),
        .blit_count_o   (blit_count),
        .blit_value_o   (blit_value),
        .intr_mask_o    (intr_mask),
        .intr_clear_o   (intr_clear),
        .sw_intr_o      (sw_intr)
    );

    blit_fill u_blit_fill (
        .clk            (clk),
        .reset_i        (reset_i),
        .start_i        (blit_start),
        .addr_i         (blit_addr),
        .count_i        (blit_count),
        .value_i        (blit_value),
        .ack_i          (blit_ack),
        .blit_req_o     (blit_req),
        .busy_o         (blit_busy),
        .done_o         (blit_done)
    );

    vram_arb u_vram_arb (
        .clk            (clk),
        .regs_req_i     (regs_req),
        .blit_req_i     (blit_req),
        .blit_ack_o     (blit_ack),
        .vram_data_o    (vram_data)
    );

    intr_ctrl u_intr_ctrl (
        .clk            (clk),
        .reset_i        (reset_i),
        .sw_intr_i      (sw_intr),
        .blit_done_i    (blit_done),
        .mask_i         (intr_mask),
        .clear_i        (intr_clear),
        .status_o       (intr_status),
        .bus_intr_o     (bus_intr_o)
    );

endmodule

`default_nettype wire

//--- dv/tb_clock.sv
// clock and reset generator for the testbench
`default_nettype none

module tb_clock (
    output logic    clk,
    output logic    reset_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk     = 1'b0;
        reset_o = 1'b1;                 // held for 5 rising edges
        repeat (5) @(posedge clk);
        #1 reset_o = 1'b0;
    end

    always #5 clk = ~clk;               // 10 ns period

endmodule

`default_nettype wire

//--- dv/tb_checker.sv
// read data and interrupt pulse checker with per-test and total reporting
`default_nettype none

module tb_checker (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic [7:0]         bus_data_i,     // DUT read byte
    input  wire logic               bus_intr_i,     // DUT interrupt strobe
    input  wire logic               chk_stb_i,      // expected byte valid
    input  wire logic [3:0]         chk_reg_i,
    input  wire logic               chk_lane_i,
    input  wire xv_pkg::addr_t      chk_addr_i,     // VRAM word for DATA reads
    input  wire logic [7:0]         chk_exp_i,
    input  wire logic               test_end_i,
    input  wire integer             test_id_i,
    input  wire integer             exp_intr_i,     // model pulse count for the test
    input  wire logic               done_i,
    output int                      errors_o
);
    timeunit 1ns;
    timeprecision 100ps;

    import xv_pkg::*;

    int pulses      = 0;    // bus_intr_o cycles seen in this test
    int t_checks    = 0;
    int t_errors    = 0;
    int checks      = 0;
    int errors      = 0;
    int tests       = 0;

    assign errors_o = errors;

    function automatic string reg_name(input logic [3:0] r);
        case (r)
            REG_INT_CTRL:   return "INT_CTRL";
            REG_WR_ADDR:    return "WR_ADDR";
            REG_DATA:       return "DATA";
            REG_RD_ADDR:    return "RD_ADDR";
            REG_SYS_CTRL:   return "SYS_CTRL";
            default:        return "BLIT";
        endcase
    endfunction

    function automatic string test_name(input int id);
        case (id)
            1:          return "reset_state";
            2:          return "vram_round_trip";
            3:          return "fill";
            4:          return "fill_under_traffic";
            5:          return "intr_masked_fill";
            default:    return "intr_sw_signal";
        endcase
    endfunction

    // negedge sampling, DUT outputs settled since the rising edge
    always @(negedge clk) begin
        if (!reset_i && bus_intr_i) begin
            pulses++;                   // strobe is one cycle wide
        end
        if (chk_stb_i) begin
            checks++;
            t_checks++;
            if (bus_data_i !== chk_exp_i) begin
                errors++;
                t_errors++;
                $display("mismatch at %0t: bus_data_o %s byte %0d addr %03h expected %02h got %02h",
                         $time, reg_name(chk_reg_i), chk_lane_i, chk_addr_i,
                         chk_exp_i, bus_data_i);
            end
        end
        if (test_end_i) begin
            checks++;
            t_checks++;
            if (pulses != exp_intr_i) begin
                errors++;
                t_errors++;
                $display("mismatch at %0t: bus_intr_o pulses expected %0d got %0d",
                         $time, exp_intr_i, pulses);
            end
            $display("test %0d %s: %0d checks, %0d errors",
                     test_id_i, test_name(test_id_i), t_checks, t_errors);
            tests++;
            pulses      = 0;
            t_checks    = 0;
            t_errors    = 0;
        end
        if (done_i) begin
            $display("totals: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_xosera.sv
// testbench top with seeded bus stimulus, VRAM and interrupt model, and run watchdog
`default_nettype none

module tb_xosera;
    timeunit 1ns;
    timeprecision 100ps;

    import xv_pkg::*;

    // rough access counts per test, for the watchdog
    localparam int T1_ACC           = 4;
    localparam int T2_ACC           = 3 * 36;
    localparam int T3_ACC           = 90;
    localparam int T4_ACC           = 180;
    localparam int T5_ACC           = 40;
    localparam int T6_ACC           = 30;
    localparam int WATCHDOG_CYCLES  = (T1_ACC + T2_ACC + T3_ACC + T4_ACC + T5_ACC + T6_ACC) * 20
                                      + 500;
    localparam int POLL_LIMIT       = 50;   // SYS_CTRL reads before giving up on a fill

    logic           clk;
    logic           reset;
    logic           bus_cs_n;
    logic           bus_rd_nwr;
    logic [3:0]     bus_reg_num;
    logic           bus_bytesel;
    logic [7:0]     bus_wdata;
    logic [7:0]     bus_rdata;
    logic           bus_intr;
    logic           chk_stb;
    logic [3:0]     chk_reg;
    logic           chk_lane;
    addr_t          chk_addr;
    logic [7:0]     chk_exp;
    logic           test_end;
    int             test_id;
    int             exp_intr;
    logic           run_done;
    int             errors;

    // reference model
    word_t          vram_m [1024];
    intr_t          mask_m;
    intr_t          status_m;
    int             exp_pulses;             // pulses expected in the current test
    int             stim_errors;            // failures seen by the stimulus itself

    tb_clock u_tb_clock (
        .clk        (clk),
        .reset_o    (reset)
    );

    xosera_core u_xosera_core (
        .clk            (clk),
        .reset_i        (reset),
        .bus_cs_n_i     (bus_cs_n),
        .bus_rd_nwr_i   (bus_rd_nwr),
        .bus_reg_num_i  (bus_reg_num),
        .bus_bytesel_i  (bus_bytesel),
        .bus_data_i     (bus_wdata),
        .bus_data_o     (bus_rdata),
        .bus_intr_o     (bus_intr)
    );

    tb_checker u_tb_checker (
        .clk        (clk),
        .reset_i    (reset),
        .bus_data_i (bus_rdata),
        .bus_intr_i (bus_intr),
        .chk_stb_i  (chk_stb),
        .chk_reg_i  (chk_reg),
        .chk_lane_i (chk_lane),
        .chk_addr_i (chk_addr),
        .chk_exp_i  (chk_exp),
        .test_end_i (test_end),
        .test_id_i  (test_id),
        .exp_intr_i (exp_intr),
        .done_i     (run_done),
        .errors_o   (errors)
    );

    // a source bit pulses only if masked and not yet pending
    function automatic void model_signal(input intr_t bits);
        if (|(bits & mask_m & ~status_m)) begin
            exp_pulses++;
        end
        status_m = status_m | bits;
    endfunction

    function automatic void model_fill(input int a, input int c, input word_t v);
        for (int i = 0; i <= c; i++) begin
            vram_m[addr_t'(a + i)] = v;     // count plus one words
        end
        model_signal(4'b0010);              // blit done bit
    endfunction

    // one strobe cycle, driven 1 ns after the edge
    task automatic access(input logic rd, input logic [3:0] r, input logic lane,
                          input logic [7:0] d);
        @(posedge clk);
        #1;
        bus_cs_n    = 1'b0;
        bus_rd_nwr  = rd;
        bus_reg_num = r;
        bus_bytesel = lane;
        bus_wdata   = d;
        @(posedge clk);
        #1;
        bus_cs_n    = 1'b1;
    endtask

    task automatic write_byte(input logic [3:0] r, input logic lane, input logic [7:0] d);
        access(1'b0, r, lane, d);
        repeat (4) @(posedge clk);          // idle gap
    endtask

    task automatic write_word(input logic [3:0] r, input word_t w);
        write_byte(r, 1'b0, w[15:8]);       // latch high byte
        write_byte(r, 1'b1, w[7:0]);        // commit
    endtask

    // read with the expected byte handed to the checker
    task automatic check_byte(input logic [3:0] r, input logic lane, input logic [7:0] exp,
                              input addr_t ad);
        access(1'b1, r, lane, 8'h00);
        chk_stb     = 1'b1;
        chk_reg     = r;
        chk_lane    = lane;
        chk_addr    = ad;
        chk_exp     = exp;
        @(posedge clk);
        #1;
        chk_stb     = 1'b0;
        repeat (3) @(posedge clk);
    endtask

    // unchecked read, for polling
    task automatic read_byte(input logic [3:0] r, input logic lane, output logic [7:0] d);
        access(1'b1, r, lane, 8'h00);
        @(negedge clk);
        d = bus_rdata;
        repeat (4) @(posedge clk);
    endtask

    task automatic check_vram(input int a, input int n);
        addr_t ad;
        write_word(REG_RD_ADDR, word_t'(a));    // prefetches the buffer
        for (int i = 0; i < n; i++) begin
            ad = addr_t'(a + i);
            check_byte(REG_DATA, 1'b0, vram_m[ad][15:8], ad);
            check_byte(REG_DATA, 1'b1, vram_m[ad][7:0], ad);    // advances
        end
    endtask

    task automatic check_intr_regs();
        check_byte(REG_INT_CTRL, 1'b0, {4'h0, mask_m}, '0);
        check_byte(REG_INT_CTRL, 1'b1, {4'h0, status_m}, '0);
    endtask

    task automatic start_fill(input int a, input int c, input word_t v);
        write_word(REG_BLIT_ADDR, word_t'(a));
        write_word(REG_BLIT_VALUE, v);
        write_word(REG_BLIT_COUNT, word_t'(c));     // commit starts the fill
    endtask

    task automatic wait_fill_idle();
        logic [7:0] d;
        int         polls;
        polls = 0;
        d = 8'h01;
        while (d[0] && polls < POLL_LIMIT) begin
            read_byte(REG_SYS_CTRL, 1'b1, d);
            polls++;
        end
        if (d[0]) begin
            $display("fill unit still busy after %0d status polls", POLL_LIMIT);
            stim_errors++;
        end
    endtask

    // fill the window with random words through DATA
    task automatic write_vram(input int a, input int n);
        word_t w;
        write_word(REG_WR_ADDR, word_t'(a));
        for (int i = 0; i < n; i++) begin
            w = word_t'($urandom());
            vram_m[addr_t'(a + i)] = w;
            write_word(REG_DATA, w);
        end
    endtask

    task automatic end_test(input int id);
        repeat (4) @(posedge clk);          // let late strobes land
        @(posedge clk);
        #1;
        test_end    = 1'b1;
        test_id     = id;
        exp_intr    = exp_pulses;
        @(posedge clk);
        #1;
        test_end    = 1'b0;
        exp_pulses  = 0;
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        int     a;
        int     b;
        int     c;
        int     n;
        word_t  v;
        intr_t  m;
        intr_t  sw;
        bus_cs_n    = 1'b1;
        bus_rd_nwr  = 1'b1;
        bus_reg_num = 4'h0;
        bus_bytesel = 1'b0;
        bus_wdata   = 8'h00;
        chk_stb     = 1'b0;
        chk_reg     = 4'h0;
        chk_lane    = 1'b0;
        chk_addr    = '0;
        chk_exp     = 8'h00;
        test_end    = 1'b0;
        test_id     = 0;
        exp_intr    = 0;
        run_done    = 1'b0;
        mask_m      = '0;
        status_m    = '0;
        exp_pulses  = 0;
        stim_errors = 0;
        void'($urandom(88));
        wait (reset == 1'b0);
        repeat (2) @(posedge clk);

        // 1: reset state
        check_intr_regs();
        check_byte(REG_SYS_CTRL, 1'b0, 8'h00, '0);
        check_byte(REG_SYS_CTRL, 1'b1, 8'h00, '0);  // not busy
        end_test(1);

        // 2: bursts written and read back
        for (int k = 0; k < 3; k++) begin
            a = $urandom_range(0, 1023);
            n = $urandom_range(4, 8);
            write_vram(a, n);
            check_vram(a, n);
        end
        end_test(2);

        // 3: fill, with one known word on each side
        a = $urandom_range(0, 1023);
        c = $urandom_range(0, 15);
        v = word_t'($urandom());
        write_vram(a - 1, c + 3);
        start_fill(a, c, v);
        model_fill(a, c, v);
        wait_fill_idle();
        check_vram(a - 1, c + 3);
        end_test(3);

        // 4: DATA writes to a disjoint region while the fill runs
        a = $urandom_range(0, 400);
        c = 40 + $urandom_range(0, 24);             // outlasts the first DATA writes
        b = 600 + $urandom_range(0, 300);
        v = word_t'($urandom());
        start_fill(a, c, v);
        model_fill(a, c, v);
        write_vram(b, 8);
        wait_fill_idle();
        check_vram(a, c + 1);
        check_vram(b, 8);
        end_test(4);

        // 5: fill done with all bits enabled
        write_word(REG_INT_CTRL, 16'h0F0F);         // mask all, clear all
        mask_m      = 4'hF;
        status_m    = '0;
        a = $urandom_range(0, 1023);
        c = $urandom_range(0, 7);
        v = word_t'($urandom());
        start_fill(a, c, v);
        model_fill(a, c, v);
        wait_fill_idle();
        check_intr_regs();
        write_byte(REG_SYS_CTRL, 1'b1, 8'h02);      // bit 1 again while pending
        model_signal(4'b0010);
        check_intr_regs();
        write_word(REG_INT_CTRL, 16'h0F02);         // clear bit 1 only
        status_m = status_m & ~intr_t'(4'b0010);
        check_intr_regs();
        end_test(5);

        // 6: software bits outside the mask, then inside it
        m  = intr_t'($urandom_range(0, 14));
        sw = ~m;
        write_word(REG_INT_CTRL, {4'h0, m, 8'h0F});
        mask_m      = m;
        status_m    = '0;
        write_byte(REG_SYS_CTRL, 1'b1, {4'h0, sw});
        model_signal(sw);                           // pending, no strobe
        check_intr_regs();
        write_word(REG_INT_CTRL, {8'h0F, 4'h0, sw});
        mask_m      = 4'hF;
        status_m    = status_m & ~sw;
        write_byte(REG_SYS_CTRL, 1'b1, {4'h0, sw});
        model_signal(sw);                           // one strobe now
        check_intr_regs();
        end_test(6);

        @(posedge clk);
        #1;
        run_done = 1'b1;
        @(posedge clk);
        #1;
        run_done = 1'b0;
        if (errors == 0 && stim_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
src/xv_pkg.sv
src/bus_regs.sv
src/blit_fill.sv
src/vram_arb.sv
src/intr_ctrl.sv
src/xosera_core.sv
dv/tb_clock.sv
dv/tb_checker.sv
dv/tb_xosera.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, and decide pass or fail from the simulation log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_xosera -f tb.f -Mdir obj_dir -o tb_xosera_sim \
    && ./obj_dir/tb_xosera_sim > sim.log 2>&1 \
    || echo "build or run failed"
cat sim.log 2>/dev/null
grep -q "^NO ERRORS$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
